// File: flist.f
+incdir+tests
rtl/ntm_math_pkg.sv
rtl/ntm_scalar_logarithm.sv
rtl/ntm_vector_logarithm.sv
rtl/ntm_matrix_logarithm.sv
tests/ntm_matrix_logarithm_tb.sv

// File: rtl/ntm_math_pkg.sv
////////////////////////////////////////////////////////////
// NTM math package
// Word width, constants and FSM state types shared by the
// scalar, vector and matrix logarithm stages
////////////////////////////////////////////////////////////

`default_nettype none

package ntm_math_pkg;

  //////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////

  // Width of data, size and modulus words
  localparam int DATA_SIZE = 32;

  // One data word
  typedef logic [DATA_SIZE-1:0] data_t;

  localparam data_t ZERO = '0;
  localparam data_t ONE  = data_t'(1);

  //////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////

  // Scalar core states for wait, power loop and result
  typedef enum logic [1:0] {
    SCALAR_IDLE,
    SCALAR_POWER,
    SCALAR_REDUCE
  } scalar_state_t;

  // Vector stage states for row wait, pair capture and core wait
  typedef enum logic [1:0] {
    VECTOR_IDLE,
    VECTOR_INPUT,
    VECTOR_WAIT
  } vector_state_t;

  // Matrix controller
  typedef enum logic [1:0] {
    STARTER_STATE,
    INPUT_I_STATE,
    INPUT_J_STATE,
    ENDER_STATE
  } matrix_state_t;

endpackage

`default_nettype wire

// File: rtl/ntm_matrix_logarithm.sv
////////////////////////////////////////////////////////////
// Matrix logarithm controller
// Walks an I x J matrix pair by pair through the vector stage
// and streams the results row by row
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ntm_matrix_logarithm (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire                  DATA_A_IN_I_ENABLE,
  input  wire                  DATA_A_IN_J_ENABLE,
  input  wire                  DATA_B_IN_I_ENABLE,
  input  wire                  DATA_B_IN_J_ENABLE,
  input  wire ntm_math_pkg::data_t MODULO_IN,
  input  wire ntm_math_pkg::data_t SIZE_I_IN,
  input  wire ntm_math_pkg::data_t SIZE_J_IN,
  input  wire ntm_math_pkg::data_t DATA_A_IN,
  input  wire ntm_math_pkg::data_t DATA_B_IN,
  output logic                 READY,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE,
  output ntm_math_pkg::data_t  DATA_OUT
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////

  matrix_state_t state;

  // Matrix geometry and modulus, latched on START
  data_t size_i_reg;
  data_t size_j_reg;
  data_t modulo_reg;

  // Row and column of the element in flight
  data_t index_i;
  data_t index_j;
  logic  last_col;
  logic  last_row;

  // Words of the current element already passed on
  logic a_seen;
  logic b_seen;

  // Accepted input strobes for this cycle
  logic a_strobe;
  logic b_strobe;

  // Vector stage
  logic  start_vector;
  logic  ready_vector;
  logic  data_a_in_enable_vector;
  logic  data_b_in_enable_vector;
  logic  data_out_enable_vector;
  data_t data_a_in_vector;
  data_t data_b_in_vector;
  data_t data_out_vector;

  //////////////////////////////////////////////////////////
  // Input routing
  //////////////////////////////////////////////////////////

  // I strobes for column zero, J strobes for the rest
  // Nothing is accepted outside the input states
  always_comb begin
    a_strobe = 1'b0;
    b_strobe = 1'b0;
    case (state)
      INPUT_I_STATE: begin
        a_strobe = DATA_A_IN_I_ENABLE && !a_seen;
        b_strobe = DATA_B_IN_I_ENABLE && !b_seen;
      end
      INPUT_J_STATE: begin
        a_strobe = DATA_A_IN_J_ENABLE && !a_seen;
        b_strobe = DATA_B_IN_J_ENABLE && !b_seen;
      end
      default: begin
        a_strobe = 1'b0;
        b_strobe = 1'b0;
      end
    endcase
  end

  assign last_col = (index_j == size_j_reg - ONE);
  assign last_row = (index_i == size_i_reg - ONE);

  // Configuration and element words
  always_ff @(posedge CLK) begin
    if (state == STARTER_STATE && START) begin
      size_i_reg <= SIZE_I_IN;
      size_j_reg <= SIZE_J_IN;
      modulo_reg <= MODULO_IN;
    end
    if (a_strobe) begin
      data_a_in_vector <= DATA_A_IN;
    end
    if (b_strobe) begin
      data_b_in_vector <= DATA_B_IN;
    end
  end

  //////////////////////////////////////////////////////////
  // Matrix FSM
  //////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state                   <= STARTER_STATE;
      index_i                 <= ZERO;
      index_j                 <= ZERO;
      a_seen                  <= 1'b0;
      b_seen                  <= 1'b0;
      start_vector            <= 1'b0;
      data_a_in_enable_vector <= 1'b0;
      data_b_in_enable_vector <= 1'b0;
      READY                   <= 1'b0;
      DATA_OUT_I_ENABLE       <= 1'b0;
      DATA_OUT_J_ENABLE       <= 1'b0;
      DATA_OUT                <= ZERO;
    end else begin
      // Strobes last one cycle
      start_vector            <= 1'b0;
      data_a_in_enable_vector <= a_strobe;
      data_b_in_enable_vector <= b_strobe;
      READY                   <= 1'b0;
      DATA_OUT_I_ENABLE       <= 1'b0;
      DATA_OUT_J_ENABLE       <= 1'b0;
      case (state)
        STARTER_STATE: begin
          if (START) begin
            index_i      <= ZERO;
            index_j      <= ZERO;
            start_vector <= 1'b1;
            state        <= INPUT_I_STATE;
          end
        end
        INPUT_I_STATE, INPUT_J_STATE: begin
          // Element done once both words went to the vector stage
          if ((a_seen || a_strobe) && (b_seen || b_strobe)) begin
            a_seen <= 1'b0;
            b_seen <= 1'b0;
            state  <= ENDER_STATE;
          end else begin
            a_seen <= a_seen || a_strobe;
            b_seen <= b_seen || b_strobe;
          end
        end
        ENDER_STATE: begin
          if (data_out_enable_vector) begin
            DATA_OUT          <= data_out_vector;
            DATA_OUT_J_ENABLE <= 1'b1;
            // Vector stage flags the end of its row
            DATA_OUT_I_ENABLE <= ready_vector;
            if (last_col) begin
              index_j <= ZERO;
              if (last_row) begin
                READY <= 1'b1;
                state <= STARTER_STATE;
              end else begin
                index_i      <= index_i + ONE;
                start_vector <= 1'b1;
                state        <= INPUT_I_STATE;
              end
            end else begin
              index_j <= index_j + ONE;
              state   <= INPUT_J_STATE;
            end
          end
        end
        default: begin
          state <= STARTER_STATE;
        end
      endcase
    end
  end

  // Row engine
  ntm_vector_logarithm vector_logarithm (
    .CLK              (CLK),
    .RST              (RST),
    .START            (start_vector),
    .DATA_A_IN_ENABLE (data_a_in_enable_vector),
    .DATA_B_IN_ENABLE (data_b_in_enable_vector),
    .MODULO_IN        (modulo_reg),
    .SIZE_IN          (size_j_reg),
    .DATA_A_IN        (data_a_in_vector),
    .DATA_B_IN        (data_b_in_vector),
    .READY            (ready_vector),
    .DATA_OUT_ENABLE  (data_out_enable_vector),
    .DATA_OUT         (data_out_vector)
  );

endmodule

`default_nettype wire

// File: rtl/ntm_scalar_logarithm.sv
////////////////////////////////////////////////////////////
// Scalar logarithm core
// floor(log_b(a)) of one pair by repeated multiplication,
// count kept reduced modulo the modulus
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ntm_scalar_logarithm (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire ntm_math_pkg::data_t MODULO_IN,
  input  wire ntm_math_pkg::data_t DATA_A_IN,
  input  wire ntm_math_pkg::data_t DATA_B_IN,
  output logic                 READY,
  output ntm_math_pkg::data_t  DATA_OUT
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////

  scalar_state_t state;

  // Operands held for the whole computation
  data_t arg_reg;
  data_t base_reg;
  data_t modulo_reg;

  // Running power b^k and reduced step count
  data_t power_reg;
  data_t count_reg;

  // Next count with modular wrap
  data_t count_inc;
  data_t count_next;
  logic  count_wrap;

  // Double width so b^(k+1) overflow is seen
  logic [2*DATA_SIZE-1:0] product;
  logic                   step_ok;

  // a == 0 or b < 2
  logic degenerate;

  //////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////

  assign degenerate = (DATA_A_IN == ZERO) || (DATA_B_IN <= ONE);

  assign product = {ZERO, power_reg} * {ZERO, base_reg};

  // Next power still fits and does not pass the argument
  assign step_ok = (product[2*DATA_SIZE-1:DATA_SIZE] == ZERO) &&
                   (product[DATA_SIZE-1:0] <= arg_reg);

  // Subtract the modulus each time the count reaches it
  // Modulus zero leaves k unreduced
  assign count_inc  = count_reg + ONE;
  assign count_wrap = (modulo_reg != ZERO) && (count_inc >= modulo_reg);
  assign count_next = count_wrap ? (count_inc - modulo_reg) : count_inc;

  // Operand capture on start
  always_ff @(posedge CLK) begin
    if (state == SCALAR_IDLE && START) begin
      arg_reg    <= DATA_A_IN;
      base_reg   <= DATA_B_IN;
      modulo_reg <= MODULO_IN;
    end
  end

  //////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= SCALAR_IDLE;
      power_reg <= ZERO;
      count_reg <= ZERO;
      READY     <= 1'b0;
      DATA_OUT  <= ZERO;
    end else begin
      // READY is a single cycle pulse
      READY <= 1'b0;
      case (state)
        SCALAR_IDLE: begin
          if (START) begin
            power_reg <= ONE;
            count_reg <= ZERO;
            // Degenerate pairs skip the power loop with k = 0
            if (degenerate) begin
              state <= SCALAR_REDUCE;
            end else begin
              state <= SCALAR_POWER;
            end
          end
        end
        SCALAR_POWER: begin
          // One multiply per cycle, at most DATA_SIZE-1 steps
          if (step_ok) begin
            power_reg <= product[DATA_SIZE-1:0];
            count_reg <= count_next;
          end else begin
            state <= SCALAR_REDUCE;
          end
        end
        SCALAR_REDUCE: begin
          // Count already below the modulus here
          DATA_OUT <= count_reg;
          READY    <= 1'b1;
          state    <= SCALAR_IDLE;
        end
        default: begin
          state <= SCALAR_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/ntm_vector_logarithm.sv
////////////////////////////////////////////////////////////
// Vector logarithm stage
// Collects the pairs of one row, runs the scalar core on each
// and streams the results out
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ntm_vector_logarithm (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire                  DATA_A_IN_ENABLE,
  input  wire                  DATA_B_IN_ENABLE,
  input  wire ntm_math_pkg::data_t MODULO_IN,
  input  wire ntm_math_pkg::data_t SIZE_IN,
  input  wire ntm_math_pkg::data_t DATA_A_IN,
  input  wire ntm_math_pkg::data_t DATA_B_IN,
  output logic                 READY,
  output logic                 DATA_OUT_ENABLE,
  output ntm_math_pkg::data_t  DATA_OUT
);

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////

  vector_state_t state;

  // Element index inside the row
  data_t index;

  // Held words of the current element
  data_t data_a_reg;
  data_t data_b_reg;
  logic  a_held;
  logic  b_held;

  // Scalar core
  logic  start_scalar;
  logic  ready_scalar;
  data_t data_out_scalar;

  //////////////////////////////////////////////////////////
  // Element capture
  //////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (DATA_A_IN_ENABLE) begin
      data_a_reg <= DATA_A_IN;
    end
    if (DATA_B_IN_ENABLE) begin
      data_b_reg <= DATA_B_IN;
    end
  end

  // Core starts in the first cycle both words are held
  assign start_scalar = (state == VECTOR_INPUT) && a_held && b_held;

  //////////////////////////////////////////////////////////
  // Row FSM
  //////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= VECTOR_IDLE;
      index           <= ZERO;
      a_held          <= 1'b0;
      b_held          <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= ZERO;
    end else begin
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        VECTOR_IDLE: begin
          if (START) begin
            index  <= ZERO;
            a_held <= 1'b0;
            b_held <= 1'b0;
            state  <= VECTOR_INPUT;
          end
        end
        VECTOR_INPUT: begin
          if (start_scalar) begin
            a_held <= 1'b0;
            b_held <= 1'b0;
            state  <= VECTOR_WAIT;
          end else begin
            // A and B may come in separate cycles
            if (DATA_A_IN_ENABLE) begin
              a_held <= 1'b1;
            end
            if (DATA_B_IN_ENABLE) begin
              b_held <= 1'b1;
            end
          end
        end
        VECTOR_WAIT: begin
          if (ready_scalar) begin
            DATA_OUT        <= data_out_scalar;
            DATA_OUT_ENABLE <= 1'b1;
            // Last element of the row closes it
            if (index == SIZE_IN - ONE) begin
              READY <= 1'b1;
              state <= VECTOR_IDLE;
            end else begin
              index <= index + ONE;
              state <= VECTOR_INPUT;
            end
          end
        end
        default: begin
          state <= VECTOR_IDLE;
        end
      endcase
    end
  end

  // Arithmetic core
  ntm_scalar_logarithm scalar_logarithm (
    .CLK       (CLK),
    .RST       (RST),
    .START     (start_scalar),
    .MODULO_IN (MODULO_IN),
    .DATA_A_IN (data_a_reg),
    .DATA_B_IN (data_b_reg),
    .READY     (ready_scalar),
    .DATA_OUT  (data_out_scalar)
  );

endmodule

`default_nettype wire

// File: tests/ntm_matrix_logarithm_tasks.svh
////////////////////////////////////////////////////////////
// Matrix logarithm testbench tasks
// Reference model, matrix driver and typed compare tasks
////////////////////////////////////////////////////////////

`ifndef NTM_MATRIX_LOGARITHM_TASKS_SVH
`define NTM_MATRIX_LOGARITHM_TASKS_SVH

// Largest k with b^k <= a, reduced unless the modulus is zero
function automatic data_t log_model(input data_t a, input data_t b, input data_t m);
  logic [63:0] power;
  data_t       k;
  if (a == 0 || b < 2) begin
    return '0;
  end
  power = 64'd1;
  k     = '0;
  while (power * {32'd0, b} <= {32'd0, a}) begin
    power = power * {32'd0, b};
    k     = k + 1;
  end
  return (m == 0) ? k : (k % m);
endfunction

task automatic compare_data(input string name, input data_t actual, input data_t expected);
  if (actual !== expected) begin
    $display("Mismatch %s: got %h expected %h", name, actual, expected);
    mismatch_count++;
  end
endtask

task automatic compare_strobe(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    $display("Mismatch %s: got %h expected %h", name, actual, expected);
    mismatch_count++;
  end
endtask

// I enables on column zero, J enables elsewhere
task automatic set_strobes(input bit first, input bit a_on, input bit b_on);
  data_a_in_i_enable = first && a_on;
  data_a_in_j_enable = !first && a_on;
  data_b_in_i_enable = first && b_on;
  data_b_in_j_enable = !first && b_on;
endtask

// Both words of one element, together or one cycle apart
task automatic drive_element(input data_t a, input data_t b, input bit first, input bit split);
  data_a_in = a;
  data_b_in = b;
  if (split) begin
    set_strobes(first, 1'b1, 1'b0);
    @(negedge CLK);
    set_strobes(first, 1'b0, 1'b1);
  end else begin
    set_strobes(first, 1'b1, 1'b1);
  end
  @(negedge CLK);
  set_strobes(first, 1'b0, 1'b0);
endtask

// Output strobe with a bound; row and end flags stay low meanwhile
task automatic wait_output(output bit seen);
  int cycles;
  seen   = 1'b0;
  cycles = 0;
  while (!seen && cycles < 2 * DATA_SIZE) begin
    if (data_out_j_enable) begin
      seen = 1'b1;
    end else begin
      compare_strobe("READY", ready, 1'b0);
      compare_strobe("DATA_OUT_I_ENABLE", data_out_i_enable, 1'b0);
      @(negedge CLK);
      cycles++;
    end
  end
endtask

// One matrix from mat_a, mat_b against mat_exp
task automatic run_matrix(input int rows, input int cols, input data_t modulo, input bit split);
  int e;
  bit seen;
  @(negedge CLK);
  start     = 1'b1;
  size_i_in = rows;
  size_j_in = cols;
  modulo_in = modulo;
  @(negedge CLK);
  start = 1'b0;
  for (int r = 0; r < rows; r++) begin
    for (int c = 0; c < cols; c++) begin
      e = r * cols + c;
      drive_element(mat_a[e], mat_b[e], c == 0, split);
      wait_output(seen);
      if (!seen) begin
        $display("No output strobe for element row %0d column %0d", r, c);
        other_count++;
      end else begin
        compare_data("DATA_OUT", data_out, mat_exp[e]);
        compare_strobe("DATA_OUT_I_ENABLE", data_out_i_enable, c == cols - 1);
        compare_strobe("READY", ready, (r == rows - 1) && (c == cols - 1));
      end
    end
  end
endtask

`endif

// File: tests/ntm_matrix_logarithm_tb.sv
////////////////////////////////////////////////////////////
// Matrix logarithm testbench
// Directed tests of the matrix logarithm engine
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ntm_matrix_logarithm_tb;

  import ntm_math_pkg::*;

  //////////////////////////////////////////////////////////
  // Run limits
  //////////////////////////////////////////////////////////

  // Element count over all tests is 1 + 4 + 12 + 2 * 4
  localparam int TOTAL_ELEMENTS = 25;
  localparam int TIMEOUT_CYCLES = TOTAL_ELEMENTS * (DATA_SIZE + 10) + 200;
  localparam logic [31:0] SEED  = 32'h71394b16;

  logic  CLK;
  logic  RST;
  logic  start;
  logic  data_a_in_i_enable;
  logic  data_a_in_j_enable;
  logic  data_b_in_i_enable;
  logic  data_b_in_j_enable;
  data_t modulo_in;
  data_t size_i_in;
  data_t size_j_in;
  data_t data_a_in;
  data_t data_b_in;
  logic  ready;
  logic  data_out_i_enable;
  logic  data_out_j_enable;
  data_t data_out;

  // Matrix under test in row major order
  data_t mat_a   [0:15];
  data_t mat_b   [0:15];
  data_t mat_exp [0:15];

  int mismatch_count = 0;
  int other_count    = 0;
  int cycle_count    = 0;

  `include "ntm_matrix_logarithm_tasks.svh"

  ntm_matrix_logarithm ntm_matrix_logarithm_inst (
    .CLK                (CLK),
    .RST                (RST),
    .START              (start),
    .DATA_A_IN_I_ENABLE (data_a_in_i_enable),
    .DATA_A_IN_J_ENABLE (data_a_in_j_enable),
    .DATA_B_IN_I_ENABLE (data_b_in_i_enable),
    .DATA_B_IN_J_ENABLE (data_b_in_j_enable),
    .MODULO_IN          (modulo_in),
    .SIZE_I_IN          (size_i_in),
    .SIZE_J_IN          (size_j_in),
    .DATA_A_IN          (data_a_in),
    .DATA_B_IN          (data_b_in),
    .READY              (ready),
    .DATA_OUT_I_ENABLE  (data_out_i_enable),
    .DATA_OUT_J_ENABLE  (data_out_j_enable),
    .DATA_OUT           (data_out)
  );

  // 40 ns clock
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Cycle limit
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: run still busy after %0d cycles", cycle_count);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////

  task automatic verify_reset_state();
    compare_strobe("READY", ready, 1'b0);
    compare_strobe("DATA_OUT_I_ENABLE", data_out_i_enable, 1'b0);
    compare_strobe("DATA_OUT_J_ENABLE", data_out_j_enable, 1'b0);
    compare_data("DATA_OUT", data_out, '0);
  endtask

  // 10^3 <= 1000 < 10^4
  task automatic known_pair_1x1();
    mat_a[0]   = 1000;
    mat_b[0]   = 10;
    mat_exp[0] = 3;
    run_matrix(1, 1, '0, 1'b0);
  endtask

  // Zero argument, base 0, base 1, then 2^9 with modulus 4
  task automatic degenerate_pairs();
    mat_a[0] = 0;
    mat_b[0] = 5;
    mat_a[1] = 100;
    mat_b[1] = 0;
    mat_a[2] = 100;
    mat_b[2] = 1;
    mat_a[3] = 512;
    mat_b[3] = 2;
    mat_exp[0] = 0;
    mat_exp[1] = 0;
    mat_exp[2] = 0;
    mat_exp[3] = 1;
    run_matrix(1, 4, 4, 1'b0);
  endtask

  task automatic random_3x4_matrix();
    for (int e = 0; e < 12; e++) begin
      // Shifted arguments spread k over its range
      mat_a[e]   = $urandom >> ($urandom % 32);
      mat_b[e]   = 2 + ($urandom % 15);
      mat_exp[e] = log_model(mat_a[e], mat_b[e], 7);
    end
    run_matrix(3, 4, 7, 1'b0);
  endtask

  task automatic idle_strobes_and_back_to_back();
    bit any_output;
    any_output = 1'b0;
    // Strobes while idle
    @(negedge CLK);
    data_a_in = 81;
    data_b_in = 3;
    data_a_in_i_enable = 1'b1;
    data_a_in_j_enable = 1'b1;
    data_b_in_i_enable = 1'b1;
    data_b_in_j_enable = 1'b1;
    @(negedge CLK);
    set_strobes(1'b0, 1'b0, 1'b0);
    repeat (40) begin
      @(negedge CLK);
      any_output = any_output || data_out_j_enable || ready;
    end
    if (any_output) begin
      $display("Output strobe after input strobes given while idle");
      other_count++;
    end
    for (int e = 0; e < 4; e++) begin
      mat_a[e]   = $urandom;
      mat_b[e]   = 2 + ($urandom % 15);
      mat_exp[e] = log_model(mat_a[e], mat_b[e], 0);
    end
    // Second run repeats the data with A and B a cycle apart
    run_matrix(2, 2, '0, 1'b0);
    run_matrix(2, 2, '0, 1'b1);
  endtask

  //////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    RST       = 1'b1;
    start     = 1'b0;
    modulo_in = '0;
    size_i_in = '0;
    size_j_in = '0;
    data_a_in = '0;
    data_b_in = '0;
    set_strobes(1'b0, 1'b0, 1'b0);
    repeat (16) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    verify_reset_state();
    known_pair_1x1();
    degenerate_pairs();
    random_3x4_matrix();
    idle_strobes_and_back_to_back();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
